//--- include/cle_macros.svh
`ifndef CLE_MACROS_SVH
`define CLE_MACROS_SVH

// --------------------
// Image geometry
// --------------------
`define CLE_IMG_W      32
`define CLE_IMG_H      32
`define CLE_COL_W      5
`define CLE_ROW_W      5
`define CLE_PIX_W      10
`define CLE_PIX_LAST   (`CLE_IMG_W * `CLE_IMG_H - 1)

// --------------------
// Memory widths
// --------------------
`define CLE_BIT_W      3
`define CLE_ROM_AW     7
`define CLE_SRAM_AW    10

// Label counter wraps past 255
`define CLE_LABEL_W    8

`endif

//--- rtl/cle_pkg.sv
`include "cle_macros.svh"

package cle_pkg;

    // Row in the upper bits, column in the lower
    typedef struct packed {
        logic [`CLE_ROW_W-1:0] row;
        logic [`CLE_COL_W-1:0] col;
    } pix_rc_t;

    // Byte address into ROM or visited RAM, bit 0 is the byte's MSB
    typedef struct packed {
        logic [`CLE_ROM_AW-1:0] byte_addr;
        logic [`CLE_BIT_W-1:0]  bit_pos;
    } pix_bb_t;

    typedef union packed {
        pix_rc_t rc;
        pix_bb_t bb;
    } pix_idx_u;

    typedef logic [`CLE_LABEL_W-1:0] label_t;

    // Listed in neighbour check order
    typedef enum logic [2:0] {
        LEFT_UP, UP, RIGHT_UP, LEFT, RIGHT, LEFT_DOWN, DOWN, RIGHT_DOWN
    } dir_t;

endpackage

//--- rtl/cle_visited_ram.sv
`timescale 1ns/100ps
`include "cle_macros.svh"

module cle_visited_ram (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`CLE_ROM_AW-1:0] wa,
    input  logic [7:0]             wd,
    input  logic [`CLE_ROM_AW-1:0] ra,
    output logic [7:0]             rq
);

    // One bit per pixel, eight pixels per word
    logic [7:0] mem [0:(1 << `CLE_ROM_AW)-1];

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wd;
        end
    end

    // --------------------
    // Read port
    // --------------------
    // Same-address read returns the old word
    always_ff @(posedge clk) begin
        rq <= mem[ra];
    end

endmodule

//--- rtl/cle_pixel_sel.sv
`timescale 1ns/100ps
`include "cle_macros.svh"

module cle_pixel_sel (
    input  logic [`CLE_BIT_W-1:0] bit_pos,
    input  logic [7:0]            rom_q,
    input  logic [7:0]            vis_q,
    output logic                  rom_pixel,
    output logic                  vis_pixel,
    output logic [7:0]            vis_marked
);

    logic [`CLE_BIT_W-1:0] bit_idx;
    logic [7:0]            bit_mask;

    // Leftmost pixel sits in the MSB
    assign bit_idx  = 3'd7 - bit_pos;
    assign bit_mask = 8'h80 >> bit_pos;

    // --------------------
    // Pixel extraction
    // --------------------
    assign rom_pixel = rom_q[bit_idx];
    assign vis_pixel = vis_q[bit_idx];

    // Visited byte with this pixel marked, written back whole
    assign vis_marked = vis_q | bit_mask;

endmodule

//--- rtl/cle_neighbor.sv
`timescale 1ns/100ps
`include "cle_macros.svh"

module cle_neighbor (
    input  cle_pkg::pix_idx_u cur_idx,
    input  cle_pkg::dir_t     dir,
    output cle_pkg::pix_idx_u nb_idx,
    output logic              nb_valid
);

    logic signed [1:0]          d_row;
    logic signed [1:0]          d_col;
    logic signed [`CLE_ROW_W:0] row_n;
    logic signed [`CLE_COL_W:0] col_n;

    // Row and column step per direction
    always_comb begin
        d_row = 2'sd0;
        d_col = 2'sd0;
        case (dir)
            cle_pkg::LEFT_UP:    begin d_row = -2'sd1; d_col = -2'sd1; end
            cle_pkg::UP:         begin d_row = -2'sd1; d_col =  2'sd0; end
            cle_pkg::RIGHT_UP:   begin d_row = -2'sd1; d_col =  2'sd1; end
            cle_pkg::LEFT:       begin d_row =  2'sd0; d_col = -2'sd1; end
            cle_pkg::RIGHT:      begin d_row =  2'sd0; d_col =  2'sd1; end
            cle_pkg::LEFT_DOWN:  begin d_row =  2'sd1; d_col = -2'sd1; end
            cle_pkg::DOWN:       begin d_row =  2'sd1; d_col =  2'sd0; end
            cle_pkg::RIGHT_DOWN: begin d_row =  2'sd1; d_col =  2'sd1; end
            default:             begin d_row =  2'sd0; d_col =  2'sd0; end
        endcase
    end

    // One extra bit so a step off either edge is visible
    assign row_n = $signed({1'b0, cur_idx.rc.row}) + d_row;
    assign col_n = $signed({1'b0, cur_idx.rc.col}) + d_col;

    always_comb begin
        nb_idx.rc.row = row_n[`CLE_ROW_W-1:0];
        nb_idx.rc.col = col_n[`CLE_COL_W-1:0];
    end

    // No wrap between rows
    assign nb_valid = (row_n >= 0) && (row_n < `CLE_IMG_H) &&
                      (col_n >= 0) && (col_n < `CLE_IMG_W);

endmodule

//--- rtl/cle_ctrl.sv
`timescale 1ns/100ps
`include "cle_macros.svh"

module cle_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rom_pixel,
    input  logic                    vis_pixel,
    input  logic [7:0]              vis_marked,
    input  cle_pkg::pix_idx_u       nb_idx,
    input  logic                    nb_valid,
    output cle_pkg::pix_idx_u       cur_idx,
    output cle_pkg::dir_t           dir,
    output logic [`CLE_ROM_AW-1:0]  rd_byte,
    output logic [`CLE_BIT_W-1:0]   bit_pos_q,
    output logic                    vis_we,
    output logic [`CLE_ROM_AW-1:0]  vis_wa,
    output logic [7:0]              vis_wd,
    output logic [`CLE_SRAM_AW-1:0] sram_a,
    output cle_pkg::label_t         sram_d,
    output logic                    sram_wen,
    output logic                    finish
);

    typedef enum logic [3:0] {
        S_CLEAR,
        S_SRCH_A,
        S_SRCH_R,
        S_SWP_A,
        S_SWP_R,
        S_NB_A,
        S_NB_R,
        S_WRITE,
        S_DONE
    } state_t;

    state_t            state;
    cle_pkg::label_t   label;
    cle_pkg::label_t   next_label;
    cle_pkg::pix_idx_u sel_idx;
    cle_pkg::pix_idx_u idx_q;
    logic              last_pix;
    logic              hit;
    logic              do_clear;
    logic              do_label;
    logic              new_comp;

    // --------------------
    // Address select
    // --------------------
    assign sel_idx   = (state == S_NB_A) ? nb_idx : cur_idx;
    assign rd_byte   = sel_idx.bb.byte_addr;
    assign bit_pos_q = idx_q.bb.bit_pos;

    assign last_pix   = (cur_idx == `CLE_PIX_LAST);
    assign next_label = label + 1'b1;

    // Foreground and not yet visited
    assign hit      = rom_pixel && !vis_pixel;
    assign do_clear = (state == S_CLEAR);
    assign new_comp = (state == S_SRCH_R) && hit;
    assign do_label = new_comp || ((state == S_NB_R) && hit);

    // Index of the pixel under test, held for the read and write cycles
    always_ff @(posedge clk) begin
        idx_q <= sel_idx;
    end

    // --------------------
    // Write payload
    // --------------------
    always_ff @(posedge clk) begin
        if (do_clear) begin
            sram_a <= cur_idx;
            sram_d <= '0;
            vis_wa <= cur_idx.bb.byte_addr;
            vis_wd <= '0;
        end else if (do_label) begin
            sram_a <= idx_q;
            sram_d <= new_comp ? next_label : label;
            vis_wa <= idx_q.bb.byte_addr;
            vis_wd <= vis_marked;
        end
    end

    // Write strobes, active in the cycle after the decision
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sram_wen <= 1'b1;
            vis_we   <= 1'b0;
        end else begin
            sram_wen <= !(do_clear || do_label);
            vis_we   <= do_clear || do_label;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            label <= '0;
        end else if (new_comp) begin
            label <= next_label;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            finish <= 1'b0;
        end else if (state == S_DONE) begin
            finish <= 1'b1;
        end
    end

    // --------------------
    // Phase FSM
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= S_CLEAR;
            cur_idx <= '0;
            dir     <= cle_pkg::LEFT_UP;
        end else begin
            case (state)
                S_CLEAR: begin
                    if (last_pix) begin
                        cur_idx <= '0;
                        state   <= S_SRCH_A;
                    end else begin
                        cur_idx <= cur_idx + 1'b1;
                    end
                end
                S_SRCH_A: begin
                    state <= S_SRCH_R;
                end
                S_SRCH_R: begin
                    if (hit) begin
                        state <= S_WRITE;
                    end else if (last_pix) begin
                        state <= S_DONE;
                    end else begin
                        cur_idx <= cur_idx + 1'b1;
                        state   <= S_SRCH_A;
                    end
                end
                S_SWP_A: begin
                    state <= S_SWP_R;
                end
                S_SWP_R: begin
                    if (rom_pixel && vis_pixel) begin
                        dir   <= cle_pkg::LEFT_UP;
                        state <= S_NB_A;
                    end else begin
                        cur_idx <= last_pix ? '0 : cur_idx + 1'b1;
                        state   <= last_pix ? S_SRCH_A : S_SWP_A;
                    end
                end
                S_NB_A: begin
                    // Out-of-image neighbours are skipped without a read
                    if (nb_valid) begin
                        state <= S_NB_R;
                    end else if (dir == cle_pkg::RIGHT_DOWN) begin
                        cur_idx <= last_pix ? '0 : cur_idx + 1'b1;
                        state   <= last_pix ? S_SRCH_A : S_SWP_A;
                    end else begin
                        dir <= cle_pkg::dir_t'(dir + 1'b1);
                    end
                end
                S_NB_R: begin
                    if (hit) begin
                        state <= S_WRITE;
                    end else if (dir == cle_pkg::RIGHT_DOWN) begin
                        cur_idx <= last_pix ? '0 : cur_idx + 1'b1;
                        state   <= last_pix ? S_SRCH_A : S_SWP_A;
                    end else begin
                        dir   <= cle_pkg::dir_t'(dir + 1'b1);
                        state <= S_NB_A;
                    end
                end
                S_WRITE: begin
                    // Every new label restarts the sweep at pixel 0
                    cur_idx <= '0;
                    state   <= S_SWP_A;
                end
                S_DONE: begin
                    state <= S_DONE;
                end
                default: begin
                    state <= S_DONE;
                end
            endcase
        end
    end

endmodule

//--- rtl/cle_top.sv
`timescale 1ns/100ps
`include "cle_macros.svh"

module cle_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [7:0]              rom_q,
    output logic [`CLE_ROM_AW-1:0]  rom_a,
    output logic [`CLE_SRAM_AW-1:0] sram_a,
    output cle_pkg::label_t         sram_d,
    output logic                    sram_wen,
    output logic                    finish
);

    cle_pkg::pix_idx_u       cur_idx;
    cle_pkg::pix_idx_u       nb_idx;
    cle_pkg::dir_t           dir;
    logic                    nb_valid;
    logic [`CLE_BIT_W-1:0]   bit_pos_q;
    logic [7:0]              vis_q;
    logic                    rom_pixel;
    logic                    vis_pixel;
    logic [7:0]              vis_marked;
    logic                    vis_we;
    logic [`CLE_ROM_AW-1:0]  vis_wa;
    logic [7:0]              vis_wd;

    cle_ctrl i_cle_ctrl (
        .clk        (clk),
        .reset      (reset),
        .rom_pixel  (rom_pixel),
        .vis_pixel  (vis_pixel),
        .vis_marked (vis_marked),
        .nb_idx     (nb_idx),
        .nb_valid   (nb_valid),
        .cur_idx    (cur_idx),
        .dir        (dir),
        .rd_byte    (rom_a),
        .bit_pos_q  (bit_pos_q),
        .vis_we     (vis_we),
        .vis_wa     (vis_wa),
        .vis_wd     (vis_wd),
        .sram_a     (sram_a),
        .sram_d     (sram_d),
        .sram_wen   (sram_wen),
        .finish     (finish)
    );

    cle_neighbor i_cle_neighbor (
        .cur_idx  (cur_idx),
        .dir      (dir),
        .nb_idx   (nb_idx),
        .nb_valid (nb_valid)
    );

    cle_pixel_sel i_cle_pixel_sel (
        .bit_pos    (bit_pos_q),
        .rom_q      (rom_q),
        .vis_q      (vis_q),
        .rom_pixel  (rom_pixel),
        .vis_pixel  (vis_pixel),
        .vis_marked (vis_marked)
    );

    // Visited RAM reads the same byte address as the ROM
    cle_visited_ram i_cle_visited_ram (
        .clk (clk),
        .we  (vis_we),
        .wa  (vis_wa),
        .wd  (vis_wd),
        .ra  (rom_a),
        .rq  (vis_q)
    );

endmodule

//--- dv/cle_tb.sv
`timescale 1ns/100ps
`include "cle_macros.svh"

module cle_tb;

    localparam int NPIX = `CLE_IMG_W * `CLE_IMG_H;

    logic                    clk;
    logic                    reset;
    logic [7:0]              rom_q;
    logic [`CLE_ROM_AW-1:0]  rom_a;
    logic [`CLE_SRAM_AW-1:0] sram_a;
    cle_pkg::label_t         sram_d;
    logic                    sram_wen;
    logic                    finish;

    logic [7:0]      rom_mem [0:(1 << `CLE_ROM_AW)-1];
    cle_pkg::label_t sram_mem [0:NPIX-1];
    cle_pkg::label_t exp_label [0:NPIX-1];
    int              wr_addr_q[$];
    cle_pkg::label_t wr_data_q[$];
    int              fg_count;
    int              comp_count;
    int              errors;
    int              checks;
    int              tests;
    int              seed;
    int              cycle_count;
    int              cycle_limit;

    cle_top i_cle_top (
        .clk      (clk),
        .reset    (reset),
        .rom_q    (rom_q),
        .rom_a    (rom_a),
        .sram_a   (sram_a),
        .sram_d   (sram_d),
        .sram_wen (sram_wen),
        .finish   (finish)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------
    // Memory models
    // --------------------
    always @(posedge clk) begin
        rom_q <= rom_mem[rom_a];
    end

    always @(posedge clk) begin
        if (sram_wen === 1'b0) begin
            sram_mem[sram_a] = sram_d;
            wr_addr_q.push_back(sram_a);
            wr_data_q.push_back(sram_d);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: finish did not rise within %0d clock cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // --------------------
    // Checks
    // --------------------
    task automatic compare_label(input int addr, input cle_pkg::label_t exp,
                                 input cle_pkg::label_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: label at address %0d is %0d, expected %0d",
                     $time, addr, act, exp);
        end
    endtask

    task automatic compare_flag(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic compare_count(input string what, input int exp, input int act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    // --------------------
    // Image and reference
    // --------------------
    function automatic logic pixel_at(input int p);
        return rom_mem[p / 8][7 - (p % 8)];
    endfunction

    task automatic set_pixel(input int r, input int c);
        int p;
        p = r * `CLE_IMG_W + c;
        rom_mem[p / 8][7 - (p % 8)] = 1'b1;
    endtask

    task automatic clear_image();
        for (int i = 0; i < (1 << `CLE_ROM_AW); i++) begin
            rom_mem[i] = 8'h00;
        end
    endtask

    // Roughly one pixel in eight set
    task automatic fill_random();
        for (int p = 0; p < NPIX; p++) begin
            if (($random(seed) & 7) == 0) begin
                set_pixel(p / `CLE_IMG_W, p % `CLE_IMG_W);
            end
        end
    endtask

    // Flood fill in raster order, 8-connected, labels from 1
    task automatic build_expected();
        int              stack[$];
        int              q;
        int              r;
        int              c;
        int              n;
        logic            seen [0:NPIX-1];
        cle_pkg::label_t lbl;
        lbl = '0;
        fg_count = 0;
        comp_count = 0;
        for (int p = 0; p < NPIX; p++) begin
            seen[p] = 1'b0;
            exp_label[p] = '0;
            if (pixel_at(p)) fg_count++;
        end
        for (int p = 0; p < NPIX; p++) begin
            if (pixel_at(p) && !seen[p]) begin
                lbl++;
                comp_count++;
                seen[p] = 1'b1;
                exp_label[p] = lbl;
                stack.push_back(p);
                while (stack.size() > 0) begin
                    q = stack.pop_back();
                    r = q / `CLE_IMG_W;
                    c = q % `CLE_IMG_W;
                    for (int dr = -1; dr <= 1; dr++) begin
                        for (int dc = -1; dc <= 1; dc++) begin
                            if ((dr != 0 || dc != 0) && r + dr >= 0 && r + dr < `CLE_IMG_H &&
                                c + dc >= 0 && c + dc < `CLE_IMG_W) begin
                                n = (r + dr) * `CLE_IMG_W + c + dc;
                                if (pixel_at(n) && !seen[n]) begin
                                    seen[n] = 1'b1;
                                    exp_label[n] = lbl;
                                    stack.push_back(n);
                                end
                            end
                        end
                    end
                end
            end
        end
    endtask

    // --------------------
    // Run control
    // --------------------
    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        wr_addr_q.delete();
        wr_data_q.delete();
        for (int a = 0; a < NPIX; a++) begin
            sram_mem[a] = cle_pkg::label_t'((a & 8'hff) ^ (a >> 8) ^ 8'ha5);
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_finish();
        cycle_limit += (fg_count + comp_count + 2) * NPIX * 20;
        while (finish !== 1'b1) @(negedge clk);
    endtask

    task automatic check_labels();
        for (int a = 0; a < NPIX; a++) begin
            compare_label(a, exp_label[a], sram_mem[a]);
        end
        // Clear pass plus one write per foreground pixel
        compare_count("SRAM write count", NPIX + fg_count, wr_addr_q.size());
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %s: %s", name, (errors == err_before) ? "pass" : "fail");
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_empty_image();
        int err0;
        err0 = errors;
        clear_image();
        build_expected();
        apply_reset();
        @(negedge clk);
        compare_flag("finish after reset", 1'b0, finish);
        compare_flag("sram_wen after reset", 1'b1, sram_wen);
        wait_finish();
        check_labels();
        for (int i = 0; i < NPIX && i < wr_addr_q.size(); i++) begin
            compare_count("clear write address", i, wr_addr_q[i]);
            compare_label(i, '0, wr_data_q[i]);
        end
        report_test("empty image", err0);
    endtask

    task automatic test_row_edges();
        int err0;
        err0 = errors;
        clear_image();
        set_pixel(0, 31);
        set_pixel(1, 0);
        build_expected();
        apply_reset();
        wait_finish();
        check_labels();
        compare_label(31, 8'd1, sram_mem[31]);
        compare_label(32, 8'd2, sram_mem[32]);
        report_test("row edges", err0);
    endtask

    task automatic test_diagonal_chain();
        int err0;
        err0 = errors;
        clear_image();
        // Peak with two arms down, then a climb back up to the right
        set_pixel(2, 15);
        for (int k = 1; k <= 8; k++) begin
            set_pixel(2 + k, 15 - k);
            set_pixel(2 + k, 15 + k);
        end
        for (int k = 1; k <= 6; k++) begin
            set_pixel(10 - k, 23 + k);
        end
        for (int r = 20; r <= 22; r++) begin
            for (int c = 5; c <= 7; c++) begin
                set_pixel(r, c);
            end
        end
        build_expected();
        apply_reset();
        wait_finish();
        check_labels();
        compare_label(4 * `CLE_IMG_W + 29, 8'd1, sram_mem[4 * `CLE_IMG_W + 29]);
        compare_label(21 * `CLE_IMG_W + 6, 8'd2, sram_mem[21 * `CLE_IMG_W + 6]);
        report_test("diagonal chain", err0);
    endtask

    task automatic test_random_sparse();
        int err0;
        err0 = errors;
        clear_image();
        fill_random();
        build_expected();
        apply_reset();
        wait_finish();
        check_labels();
        report_test("random sparse", err0);
    endtask

    task automatic test_finish_and_reset();
        int err0;
        int n_wr;
        err0 = errors;
        clear_image();
        fill_random();
        build_expected();
        apply_reset();
        wait_finish();
        n_wr = wr_addr_q.size();
        cycle_limit += 100;
        repeat (50) begin
            @(negedge clk);
            compare_flag("finish held", 1'b1, finish);
        end
        compare_count("writes after finish", n_wr, wr_addr_q.size());
        apply_reset();
        @(negedge clk);
        compare_flag("finish after reset", 1'b0, finish);
        // Abort partway, then rerun from scratch
        cycle_limit += 1600;
        repeat (1500) @(posedge clk);
        @(negedge clk);
        compare_flag("finish before mid-run reset", 1'b0, finish);
        apply_reset();
        wait_finish();
        check_labels();
        report_test("finish and reset", err0);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        tests = 0;
        cycle_count = 0;
        cycle_limit = 1000;
        seed = 32'h1a16_f544;
        reset = 1'b1;
        rom_q = 8'h00;
        test_empty_image();
        test_row_edges();
        test_diagonal_chain();
        test_random_sparse();
        test_finish_and_reset();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
rtl/cle_pkg.sv
rtl/cle_visited_ram.sv
rtl/cle_pixel_sel.sv
rtl/cle_neighbor.sv
rtl/cle_ctrl.sv
rtl/cle_top.sv
dv/cle_tb.sv
